// File: bench/tb_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module tb_tracker;
  import tracker_pkg::*;

  localparam int H_ACTIVE   = 32;
  localparam int H_TOTAL    = 40;
  localparam int V_ACTIVE   = 16;
  localparam int V_TOTAL    = 20;
  localparam int MAX_CYCLES = 8 * 800 + 2000; // eight frames plus slack

  logic        clk_pixel;
  logic        recent_reset;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [1:0]  wb_adr;
  logic [31:0] wb_dat_w;
  logic [31:0] wb_dat_r;
  logic        wb_ack;
  rgb565_t     pixel;
  hcoord_t     req_h;
  vcoord_t     req_v;
  rgb888_t     rgb;
  hcoord_t     out_h;
  vcoord_t     out_v;
  logic        out_active;
  hcoord_t     x_com;
  vcoord_t     y_com;
  logic        com_valid;

  // model of the register state and of the centre
  chan_sel_t   chan_m;
  view_t       view_m;
  chan_t       lower_m;
  chan_t       upper_m;
  hcoord_t     held_x;
  vcoord_t     held_y;
  hcoord_t     pend_x;    // reference centre of the frame just scanned
  vcoord_t     pend_y;
  count_t      pend_n;
  rgb888_t     exp_rgb;   // expected output for the current request
  logic [31:0] exp_rd;    // expected Wishbone read data
  int          frame_no;
  int          cycles;
  int          bus_errors;
  int          chk_errors;
  logic        done;
  int          rx0[16];   // rectangle bounds per frame
  int          rx1[16];
  int          ry0[16];
  int          ry1[16];
  event        frame_done;

  tracker_top #(
    .H_ACTIVE(H_ACTIVE), .H_TOTAL(H_TOTAL), .V_ACTIVE(V_ACTIVE), .V_TOTAL(V_TOTAL)
  ) tracker_top_i (
    .clk_pixel(clk_pixel), .recent_reset(recent_reset),
    .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_we_i(wb_we), .wb_adr_i(wb_adr),
    .wb_dat_i(wb_dat_w), .wb_dat_o(wb_dat_r), .wb_ack_o(wb_ack),
    .pixel_i(pixel), .req_hcount_o(req_h), .req_vcount_o(req_v),
    .rgb_o(rgb), .out_hcount_o(out_h), .out_vcount_o(out_v),
    .out_active_o(out_active), .x_com_o(x_com), .y_com_o(y_com),
    .com_valid_o(com_valid)
  );

  tracker_checker #(
    .H_ACTIVE(H_ACTIVE), .H_TOTAL(H_TOTAL), .V_ACTIVE(V_ACTIVE), .V_TOTAL(V_TOTAL)
  ) checker_i (
    .clk_pixel(clk_pixel), .recent_reset(recent_reset),
    .req_hcount_i(req_h), .req_vcount_i(req_v), .rgb_i(rgb),
    .out_hcount_i(out_h), .out_vcount_i(out_v), .out_active_i(out_active),
    .x_com_i(x_com), .y_com_i(y_com), .com_valid_i(com_valid),
    .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_we_i(wb_we), .wb_ack_i(wb_ack),
    .wb_dat_i(wb_dat_r), .exp_rgb_i(exp_rgb), .exp_rd_i(exp_rd),
    .pend_n_i(pend_n), .pend_x_i(pend_x), .pend_y_i(pend_y),
    .error_count_o(chk_errors)
  );

  // red box on dim grey, grey channels 32/40/48 once widened
  function automatic rgb565_t pattern(int f, int h, int v);
    int k;
    k = f % 16;
    if (h >= rx0[k] && h <= rx1[k] && v >= ry0[k] && v <= ry1[k])
      return 16'hF800;
    return {5'd4, 6'd10, 5'd6};
  endfunction

  function automatic chan_t channel_of(rgb565_t p, chan_sel_t s);
    case (s)
      CH_GREEN: return {p[10:5], 2'b00};
      CH_BLUE:  return {p[4:0], 3'b000};
      default:  return {p[15:11], 3'b000};
    endcase
  endfunction

  // output pixel rule for one request
  function automatic rgb888_t expected_pixel(rgb565_t p, int h, int v);
    rgb888_t cam;
    chan_t   c;
    cam = {p[15:11], 3'b000, p[10:5], 2'b00, p[4:0], 3'b000};
    c   = channel_of(p, chan_m);
    if (h >= H_ACTIVE || v >= V_ACTIVE)
      return '0; // blanking
    case (view_m)
      VIEW_CHANNEL:   return {c, c, c};
      VIEW_MASK:      return (c >= lower_m && c <= upper_m) ? 24'hFFFFFF : 24'h0;
      VIEW_CROSSHAIR: return (h == held_x || v == held_y) ? 24'hFFFFFF : cam;
      default:        return cam;
    endcase
  endfunction

  // floor of the mean masked coordinate of frame f
  task automatic frame_centre(input int f, output count_t n, output hcoord_t cx,
                              output vcoord_t cy);
    int   sx;
    int   sy;
    int   cnt;
    chan_t c;
    sx  = 0;
    sy  = 0;
    cnt = 0;
    for (int v = 0; v < V_ACTIVE; v++) begin
      for (int h = 0; h < H_ACTIVE; h++) begin
        c = channel_of(pattern(f, h, v), chan_m);
        if (c >= lower_m && c <= upper_m) begin
          sx += h;
          sy += v;
          cnt++;
        end
      end
    end
    n  = count_t'(cnt);
    cx = (cnt != 0) ? hcoord_t'(sx / cnt) : '0;
    cy = (cnt != 0) ? vcoord_t'(sy / cnt) : '0;
  endtask

  initial begin
    clk_pixel = 1'b0;
    forever #2 clk_pixel = ~clk_pixel;
  end

  // pixel source, 1 ns after the edge
  always @(posedge clk_pixel) begin
    #1;
    pixel   = pattern(frame_no, req_h, req_v);
    exp_rgb = expected_pixel(pixel, req_h, req_v);
    if (com_valid) begin
      held_x = pend_x; // new centre from this edge on
      held_y = pend_y;
    end
    if (req_h == H_ACTIVE - 1 && req_v == V_ACTIVE - 1) begin
      frame_centre(frame_no, pend_n, pend_x, pend_y);
      frame_no++;
      -> frame_done;
    end
  end

  always @(posedge clk_pixel) begin
    cycles++;
    if (cycles >= MAX_CYCLES && !done) begin
      done = 1'b1;
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("*** FAILED ***");
      $finish;
    end
  end

  // one classic cycle, held until ack is seen
  task automatic bus_access(input logic we, input logic [1:0] adr, input logic [31:0] dat);
    int waited;
    waited   = 0;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = dat;
    do begin
      @(negedge clk_pixel);
      waited++;
    end while (!wb_ack && waited < 8);
    if (!wb_ack) begin
      $display("no Wishbone ack for address %0d at %0t", adr, $time);
      bus_errors++;
    end
    @(posedge clk_pixel);
    #1;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    @(posedge clk_pixel); // idle gap
    #1;
  endtask

  task automatic reg_write(input logic [1:0] adr, input logic [31:0] dat);
    bus_access(1'b1, adr, dat);
    case (adr)
      REG_CTRL: begin
        chan_m = chan_sel_t'(dat[1:0]);
        view_m = view_t'(dat[3:2]);
      end
      REG_LOWER: lower_m = dat[7:0];
      REG_UPPER: upper_m = dat[7:0];
      default: ;
    endcase
  endtask

  task automatic reg_read(input logic [1:0] adr, input logic [31:0] expect_val);
    exp_rd = expect_val; // checker compares in the ack cycle
    bus_access(1'b0, adr, 32'd0);
  endtask

  task automatic configure(input view_t vw, input chan_sel_t ch, input chan_t lo,
                           input chan_t hi);
    reg_read(REG_COM, {6'd0, held_y, 5'd0, held_x});
    reg_write(REG_CTRL, {28'd0, vw, ch});
    reg_write(REG_LOWER, {24'd0, lo});
    reg_write(REG_UPPER, {24'd0, hi});
  endtask

  initial begin
    void'($urandom(83));
    for (int f = 0; f < 16; f++) begin
      rx0[f] = $urandom % 24;
      rx1[f] = rx0[f] + 2 + $urandom % 6;
      ry0[f] = $urandom % 11;
      ry1[f] = ry0[f] + 2 + $urandom % 4;
    end
    recent_reset = 1'b1;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    wb_adr = 2'd0;
    wb_dat_w = 32'd0;
    pixel = '0;
    chan_m = CH_RED;      // reset values of the registers
    view_m = VIEW_CAMERA;
    lower_m = 8'd0;
    upper_m = 8'd255;
    held_x = '0;
    held_y = '0;
    pend_x = '0;
    pend_y = '0;
    pend_n = '0;
    exp_rgb = '0;
    exp_rd = '0;
    frame_no = 0;
    cycles = 0;
    bus_errors = 0;
    done = 1'b0;
    repeat (3) @(posedge clk_pixel);
    #1 recent_reset = 1'b0;

    @(frame_done); // frame 0 runs on reset values
    reg_write(REG_LOWER, 32'd200);
    reg_read(REG_LOWER, 32'd200);
    reg_write(REG_UPPER, 32'd255);
    reg_read(REG_UPPER, 32'd255);
    reg_write(REG_CTRL, {28'd0, VIEW_CAMERA, CH_RED});
    reg_read(REG_CTRL, {28'd0, VIEW_CAMERA, CH_RED});
    reg_write(REG_COM, 32'hFFFF_FFFF); // ignored
    reg_read(REG_COM, {6'd0, held_y, 5'd0, held_x});

    @(frame_done);
    configure(VIEW_CHANNEL, CH_GREEN, 8'd36, 8'd44); // background only
    @(frame_done);
    configure(VIEW_MASK, CH_BLUE, 8'd44, 8'd52); // background only, blue alone passes
    @(frame_done);
    configure(VIEW_CROSSHAIR, CH_RED, 8'd200, 8'd255);
    @(frame_done);
    configure(VIEW_CROSSHAIR, CH_RED, 8'd250, 8'd251); // nothing passes
    @(frame_done);
    configure(VIEW_CROSSHAIR, CH_RED, 8'd200, 8'd255);
    @(frame_done);
    reg_read(REG_COM, {6'd0, held_y, 5'd0, held_x});
    @(frame_done); // pulse count of the last frame gets checked here
    repeat (4) @(negedge clk_pixel);

    done = 1'b1;
    $display("errors: checker %0d, bus %0d", chk_errors, bus_errors);
    if (chk_errors == 0 && bus_errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: bench/tracker_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module tracker_asserts #(
  parameter bit ACK_CHECK = 1'b1 // ack rule, else the com_valid spacing rule
) (
  input wire clk_pixel,
  input wire recent_reset,
  input wire strobe_i  // wishbone ack or divider result strobe
);

  if (ACK_CHECK) begin : g_ack
    ack_single: assert property (@(posedge clk_pixel) disable iff (recent_reset)
      strobe_i |=> !strobe_i)
      else $error("Wishbone ack high for two cycles in a row");
  end else begin : g_valid
    valid_spacing: assert property (@(posedge clk_pixel) disable iff (recent_reset)
      strobe_i |=> !strobe_i ##1 !strobe_i)
      else $error("com_valid pulses closer than 3 cycles apart");
  end

endmodule

bind wb_config_regs tracker_asserts #(.ACK_CHECK(1'b1)) wb_ack_checks (
  .clk_pixel(clk_pixel), .recent_reset(recent_reset), .strobe_i(wb_ack_o));

bind com_divider_fsm tracker_asserts #(.ACK_CHECK(1'b0)) div_valid_checks (
  .clk_pixel(clk_pixel), .recent_reset(recent_reset), .strobe_i(com_valid_o));

`default_nettype wire

// File: bench/tracker_checker.sv
`timescale 1ns/1ps
`default_nettype none

module tracker_checker #(
  parameter int H_ACTIVE = 32,
  parameter int H_TOTAL  = 40,
  parameter int V_ACTIVE = 16,
  parameter int V_TOTAL  = 20
) (
  input  wire                       clk_pixel,
  input  wire                       recent_reset,
  input  wire tracker_pkg::hcoord_t req_hcount_i,
  input  wire tracker_pkg::vcoord_t req_vcount_i,
  input  wire tracker_pkg::rgb888_t rgb_i,
  input  wire tracker_pkg::hcoord_t out_hcount_i,
  input  wire tracker_pkg::vcoord_t out_vcount_i,
  input  wire                       out_active_i,
  input  wire tracker_pkg::hcoord_t x_com_i,
  input  wire tracker_pkg::vcoord_t y_com_i,
  input  wire                       com_valid_i,
  input  wire                       wb_cyc_i,
  input  wire                       wb_stb_i,
  input  wire                       wb_we_i,
  input  wire                       wb_ack_i,
  input  wire [31:0]                wb_dat_i,
  input  wire tracker_pkg::rgb888_t exp_rgb_i, // reference for the current request
  input  wire [31:0]                exp_rd_i,
  input  wire tracker_pkg::count_t  pend_n_i,  // reference of the last finished frame
  input  wire tracker_pkg::hcoord_t pend_x_i,
  input  wire tracker_pkg::vcoord_t pend_y_i,
  output int                        error_count_o
);
  import tracker_pkg::*;

  int      errors = 0;
  int      pulses = 0;      // com_valid pulses since the last frame end
  int      scan_h = 0;      // expected request position of the scan
  int      scan_v = 0;
  count_t  prev_n = '0;     // masked count the pulses belong to
  logic    rst_q = 1'b1;
  logic    d1_ok = 1'b0;
  logic    d2_ok = 1'b0;
  rgb888_t d1_rgb, d2_rgb;  // two-stage copy of the DUT pipeline
  hcoord_t d1_h, d2_h;
  vcoord_t d1_v, d2_v;
  logic    d1_act, d2_act;

  assign error_count_o = errors;

  task automatic mismatch(input string name, input logic [31:0] exp_v,
                          input logic [31:0] act_v);
    $display("Mismatch at %0t: %s expected %h got %h", $time, name, exp_v, act_v);
    errors++;
  endtask

  // negedge sampling, all DUT outputs settled
  always @(negedge clk_pixel) begin
    rst_q <= recent_reset;
    if (rst_q && !recent_reset) begin // first sample out of reset
      if (com_valid_i !== 1'b0) mismatch("com_valid_o", 32'd0, com_valid_i);
      if (rgb_i !== '0)         mismatch("rgb_o", 32'd0, rgb_i);
      if (x_com_i !== '0)       mismatch("x_com_o", 32'd0, x_com_i);
      if (y_com_i !== '0)       mismatch("y_com_o", 32'd0, y_com_i);
      if (wb_ack_i !== 1'b0)    mismatch("wb_ack_o", 32'd0, wb_ack_i);
    end

    // raster scan, one position per clock from 0,0 out of reset
    if (recent_reset) begin
      scan_h = 0;
      scan_v = 0;
    end else begin
      if (req_hcount_i !== hcoord_t'(scan_h)) mismatch("req_hcount_o", scan_h, req_hcount_i);
      if (req_vcount_i !== vcoord_t'(scan_v)) mismatch("req_vcount_o", scan_v, req_vcount_i);
      scan_h = (scan_h == H_TOTAL - 1) ? 0 : scan_h + 1;
      if (scan_h == 0)
        scan_v = (scan_v == V_TOTAL - 1) ? 0 : scan_v + 1;
    end

    d1_ok  <= !recent_reset;
    d2_ok  <= d1_ok;
    d1_rgb <= exp_rgb_i;
    d2_rgb <= d1_rgb;
    d1_h   <= req_hcount_i;
    d2_h   <= d1_h;
    d1_v   <= req_vcount_i;
    d2_v   <= d1_v;
    d1_act <= (req_hcount_i < H_ACTIVE) && (req_vcount_i < V_ACTIVE);
    d2_act <= d1_act;
    if (d2_ok) begin // output now belongs to the request two cycles back
      if (rgb_i !== d2_rgb)         mismatch("rgb_o", d2_rgb, rgb_i);
      if (out_hcount_i !== d2_h)    mismatch("out_hcount_o", d2_h, out_hcount_i);
      if (out_vcount_i !== d2_v)    mismatch("out_vcount_o", d2_v, out_vcount_i);
      if (out_active_i !== d2_act)  mismatch("out_active_o", d2_act, out_active_i);
    end

    if (wb_ack_i && !(wb_cyc_i && wb_stb_i)) begin
      $display("Wishbone ack without a request at %0t", $time);
      errors++;
    end
    if (wb_ack_i && !wb_we_i && wb_dat_i !== exp_rd_i)
      mismatch("wb_dat_o", exp_rd_i, wb_dat_i);

    if (com_valid_i && !recent_reset) begin
      pulses++;
      if (x_com_i !== pend_x_i) mismatch("x_com_o", pend_x_i, x_com_i);
      if (y_com_i !== pend_y_i) mismatch("y_com_o", pend_y_i, y_com_i);
    end

    if (!recent_reset && req_hcount_i == H_ACTIVE - 1 && req_vcount_i == V_ACTIVE - 1) begin
      if (prev_n != 0 && pulses != 1) begin
        $display("expected one com_valid pulse per frame, saw %0d before %0t", pulses, $time);
        errors++;
      end
      if (prev_n == 0 && pulses != 0) begin
        $display("com_valid pulsed for a frame with no masked pixels, before %0t", $time);
        errors++;
      end
      pulses = 0;
      prev_n = pend_n_i; // reference of the frame that ends now
    end
  end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_tracker \
  -f verilog.f -o sim_tracker
./obj_dir/sim_tracker > sim.log 2>&1 || true
cat sim.log
if grep -q '\*\*\* FAILED \*\*\*' sim.log; then
  exit 1
fi
if ! grep -q '\*\*\* PASSED \*\*\*' sim.log; then
  echo "simulation ended without a result"
  exit 1
fi

// File: verilog.f
verilog/tracker_pkg.sv
verilog/video_timing.sv
verilog/wb_config_regs.sv
verilog/mask_threshold.sv
verilog/com_accumulator.sv
verilog/com_divider_fsm.sv
verilog/video_mux.sv
verilog/tracker_top.sv
bench/tracker_asserts.sv
bench/tracker_checker.sv
bench/tb_tracker.sv

// File: verilog/com_accumulator.sv
`timescale 1ns/1ps
`default_nettype none

module com_accumulator (
  input  wire                       clk_pixel,
  input  wire                       recent_reset,
  input  wire                       mask_i,
  input  wire tracker_pkg::hcoord_t hcount_i,
  input  wire tracker_pkg::vcoord_t vcount_i,
  input  wire                       frame_end_i,
  output tracker_pkg::sum_t         x_sum_o,  // frame totals, stable while dividing
  output tracker_pkg::sum_t         y_sum_o,
  output tracker_pkg::count_t       count_o,
  output logic                      div_start_o
);
  import tracker_pkg::*;

  sum_t   x_acc;
  sum_t   y_acc;
  count_t n_acc;
  sum_t   x_next; // running totals with the current pixel added
  sum_t   y_next;
  count_t n_next;

  always_comb begin
    x_next = x_acc + (mask_i ? sum_t'(hcount_i) : '0);
    y_next = y_acc + (mask_i ? sum_t'(vcount_i) : '0);
    n_next = n_acc + (mask_i ? count_t'(1) : '0);
  end

  always_ff @(posedge clk_pixel) begin
    if (recent_reset) begin
      x_acc       <= '0;
      y_acc       <= '0;
      n_acc       <= '0;
      div_start_o <= 1'b0;
    end else if (frame_end_i) begin
      x_acc       <= '0; // next frame starts clean
      y_acc       <= '0;
      n_acc       <= '0;
      div_start_o <= (n_next != '0); // empty frame keeps the old centre
    end else begin
      x_acc       <= x_next;
      y_acc       <= y_next;
      n_acc       <= n_next;
      div_start_o <= 1'b0;
    end
  end

  // hand-off registers, only loaded at frame end
  always_ff @(posedge clk_pixel) begin
    if (frame_end_i) begin
      x_sum_o <= x_next;
      y_sum_o <= y_next;
      count_o <= n_next;
    end
  end

endmodule

`default_nettype wire

// File: verilog/com_divider_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module com_divider_fsm (
  input  wire                        clk_pixel,
  input  wire                        recent_reset,
  input  wire                        div_start_i,
  input  wire tracker_pkg::sum_t     x_sum_i,
  input  wire tracker_pkg::sum_t     y_sum_i,
  input  wire tracker_pkg::count_t   count_i,
  output tracker_pkg::hcoord_t       x_com_o,
  output tracker_pkg::vcoord_t       y_com_o,
  output logic                       com_valid_o
);
  import tracker_pkg::*;

  div_state_t  state;
  logic [4:0]  bit_cnt;  // quotient bits left minus one
  sum_t        dvd;      // dividend shifts out the top, quotient shifts in
  sum_t        y_hold;   // y sum parked during the x pass
  count_t      dvs;      // divisor, masked pixel count
  count_t      rem;      // partial remainder, always below dvs
  hcoord_t     x_res;    // x quotient waiting for the y pass
  logic [21:0] trial;
  logic [21:0] diff;
  logic        q_bit;
  sum_t        quo_next;

  // one restoring step per clock
  always_comb begin
    trial    = {rem, dvd[31]};
    diff     = trial - {1'b0, dvs};
    q_bit    = (trial >= {1'b0, dvs});
    quo_next = {dvd[30:0], q_bit};
  end

  always_ff @(posedge clk_pixel) begin
    if (recent_reset) begin
      state       <= DIV_IDLE;
      com_valid_o <= 1'b0;
      x_com_o     <= '0;
      y_com_o     <= '0;
    end else begin
      com_valid_o <= 1'b0;
      case (state)
        DIV_IDLE: if (div_start_i) state <= DIV_X; // start while busy is dropped
        DIV_X:    if (bit_cnt == 5'd0) state <= DIV_Y;
        DIV_Y:    if (bit_cnt == 5'd0) state <= DIV_DONE;
        DIV_DONE: begin
          x_com_o     <= x_res;
          y_com_o     <= dvd[9:0]; // y quotient left in dvd by the last step
          com_valid_o <= 1'b1;     // same edge as the new centre
          state       <= DIV_IDLE;
        end
        default:  state <= DIV_IDLE;
      endcase
    end
  end

  // datapath
  always_ff @(posedge clk_pixel) begin
    case (state)
      DIV_IDLE: begin
        if (div_start_i) begin
          dvd     <= x_sum_i;
          y_hold  <= y_sum_i;
          dvs     <= count_i;
          rem     <= '0;
          bit_cnt <= 5'd31;
        end
      end
      DIV_X, DIV_Y: begin
        dvd     <= quo_next;
        rem     <= q_bit ? diff[20:0] : trial[20:0];
        bit_cnt <= bit_cnt - 1'b1; // wraps to 31 ready for the y pass
        if (state == DIV_X && bit_cnt == 5'd0) begin
          x_res <= quo_next[10:0]; // mean fits the column width
          dvd   <= y_hold;
          rem   <= '0;
        end
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// File: verilog/mask_threshold.sv
`timescale 1ns/1ps
`default_nettype none

module mask_threshold #(
  parameter int H_ACTIVE = 1280,
  parameter int V_ACTIVE = 720
) (
  input  wire                         clk_pixel,
  input  wire                         recent_reset,
  input  wire tracker_pkg::rgb565_t   pixel_i,
  input  wire tracker_pkg::hcoord_t   req_hcount_i,
  input  wire tracker_pkg::vcoord_t   req_vcount_i,
  input  wire                         req_active_i,
  input  wire                         frame_end_i,
  input  wire tracker_pkg::chan_sel_t chan_sel_i,
  input  wire tracker_pkg::chan_t     lower_i,
  input  wire tracker_pkg::chan_t     upper_i,
  output logic                        mask_o,
  output tracker_pkg::rgb565_t        pix_o,
  output tracker_pkg::chan_t          chan_o,
  output tracker_pkg::hcoord_t        hcount_o,
  output tracker_pkg::vcoord_t        vcount_o,
  output logic                        active_o,
  output logic                        frame_end_o
);
  import tracker_pkg::*;

  chan_t chan;    // selected channel, widened to 8 bits
  logic  in_frame;
  logic  hit;

  always_comb begin
    case (chan_sel_i)
      CH_RED:   chan = {pixel_i[15:11], 3'b000};
      CH_GREEN: chan = {pixel_i[10:5], 2'b00};
      CH_BLUE:  chan = {pixel_i[4:0], 3'b000};
      default:  chan = 8'd0; // unused encoding reads as black
    endcase
  end

  // mask only inside the visible area so blanking never leaks into the sums
  assign in_frame = (req_hcount_i < H_ACTIVE) && (req_vcount_i < V_ACTIVE);
  assign hit      = in_frame && (chan >= lower_i) && (chan <= upper_i);

  // stage 1 flags
  always_ff @(posedge clk_pixel) begin
    if (recent_reset) begin
      mask_o      <= 1'b0;
      active_o    <= 1'b0;
      frame_end_o <= 1'b0;
    end else begin
      mask_o      <= hit;
      active_o    <= req_active_i;
      frame_end_o <= frame_end_i; // stays aligned with the last pixel's mask
    end
  end

  // stage 1 payload
  always_ff @(posedge clk_pixel) begin
    pix_o    <= pixel_i;
    chan_o   <= chan;
    hcount_o <= req_hcount_i;
    vcount_o <= req_vcount_i;
  end

endmodule

`default_nettype wire

// File: verilog/tracker_pkg.sv
`default_nettype none

package tracker_pkg;

  typedef logic [10:0] hcoord_t; // column, up to 2047
  typedef logic [9:0]  vcoord_t; // row, up to 1023
  typedef logic [15:0] rgb565_t; // r[15:11] g[10:5] b[4:0]
  typedef logic [23:0] rgb888_t; // r[23:16] g[15:8] b[7:0]
  typedef logic [7:0]  chan_t;   // one widened channel or a bound
  typedef logic [31:0] sum_t;    // coordinate sum over a frame
  typedef logic [20:0] count_t;  // masked pixels per frame, 1280*720 fits

  typedef enum logic [1:0] {
    CH_RED,
    CH_GREEN,
    CH_BLUE
  } chan_sel_t;

  typedef enum logic [1:0] {
    VIEW_CAMERA,    // plain camera colour
    VIEW_CHANNEL,   // selected channel as gray
    VIEW_MASK,      // threshold result
    VIEW_CROSSHAIR  // camera with com lines on top
  } view_t;

  typedef enum logic [1:0] {
    DIV_IDLE,
    DIV_X,
    DIV_Y,
    DIV_DONE
  } div_state_t;

  // wishbone register map, word addresses
  localparam logic [1:0] REG_CTRL  = 2'd0; // chan [1:0], view [3:2]
  localparam logic [1:0] REG_LOWER = 2'd1;
  localparam logic [1:0] REG_UPPER = 2'd2;
  localparam logic [1:0] REG_COM   = 2'd3; // read only, x [10:0], y [25:16]

endpackage

`default_nettype wire

// File: verilog/tracker_top.sv
`timescale 1ns/1ps
`default_nettype none

module tracker_top #(
  parameter int H_ACTIVE = 1280,
  parameter int H_TOTAL  = 1650,
  parameter int V_ACTIVE = 720,
  parameter int V_TOTAL  = 750
) (
  input  wire                       clk_pixel,
  input  wire                       recent_reset,
  input  wire                       wb_cyc_i,
  input  wire                       wb_stb_i,
  input  wire                       wb_we_i,
  input  wire  [1:0]                wb_adr_i,
  input  wire  [31:0]               wb_dat_i,
  output logic [31:0]               wb_dat_o,
  output logic                      wb_ack_o,
  input  wire tracker_pkg::rgb565_t pixel_i, // pixel at req coordinate, same cycle
  output tracker_pkg::hcoord_t      req_hcount_o,
  output tracker_pkg::vcoord_t      req_vcount_o,
  output tracker_pkg::rgb888_t      rgb_o,
  output tracker_pkg::hcoord_t      out_hcount_o,
  output tracker_pkg::vcoord_t      out_vcount_o,
  output logic                      out_active_o,
  output tracker_pkg::hcoord_t      x_com_o,
  output tracker_pkg::vcoord_t      y_com_o,
  output logic                      com_valid_o
);
  import tracker_pkg::*;

  logic      req_active, req_frame_end;
  chan_sel_t chan_sel;
  view_t     view;
  chan_t     lower, upper;
  // stage 1
  logic      s1_mask, s1_active, s1_frame_end;
  rgb565_t   s1_pix;
  chan_t     s1_chan;
  hcoord_t   s1_hcount;
  vcoord_t   s1_vcount;
  // frame totals to the divider
  sum_t      x_sum, y_sum;
  count_t    count;
  logic      div_start;

  video_timing #(.H_ACTIVE(H_ACTIVE), .H_TOTAL(H_TOTAL),
                 .V_ACTIVE(V_ACTIVE), .V_TOTAL(V_TOTAL)) video_timing_i (
    .clk_pixel, .recent_reset, .req_hcount_o, .req_vcount_o,
    .req_active_o(req_active), .frame_end_o(req_frame_end));

  wb_config_regs wb_config_regs_i (
    .clk_pixel, .recent_reset, .wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_adr_i,
    .wb_dat_i, .wb_dat_o, .wb_ack_o, .x_com_i(x_com_o), .y_com_i(y_com_o),
    .chan_sel_o(chan_sel), .view_o(view), .lower_o(lower), .upper_o(upper));

  mask_threshold #(.H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE)) mask_threshold_i (
    .clk_pixel, .recent_reset, .pixel_i, .req_hcount_i(req_hcount_o),
    .req_vcount_i(req_vcount_o), .req_active_i(req_active),
    .frame_end_i(req_frame_end), .chan_sel_i(chan_sel), .lower_i(lower),
    .upper_i(upper), .mask_o(s1_mask), .pix_o(s1_pix), .chan_o(s1_chan),
    .hcount_o(s1_hcount), .vcount_o(s1_vcount), .active_o(s1_active),
    .frame_end_o(s1_frame_end));

  com_accumulator com_accumulator_i (
    .clk_pixel, .recent_reset, .mask_i(s1_mask), .hcount_i(s1_hcount),
    .vcount_i(s1_vcount), .frame_end_i(s1_frame_end), .x_sum_o(x_sum),
    .y_sum_o(y_sum), .count_o(count), .div_start_o(div_start));

  com_divider_fsm com_divider_fsm_i (
    .clk_pixel, .recent_reset, .div_start_i(div_start), .x_sum_i(x_sum),
    .y_sum_i(y_sum), .count_i(count), .x_com_o, .y_com_o, .com_valid_o);

  video_mux #(.H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE)) video_mux_i (
    .clk_pixel, .recent_reset, .view_i(view), .pix_i(s1_pix), .chan_i(s1_chan),
    .mask_i(s1_mask), .hcount_i(s1_hcount), .vcount_i(s1_vcount),
    .active_i(s1_active), .x_com_i(x_com_o), .y_com_i(y_com_o), .rgb_o,
    .out_hcount_o, .out_vcount_o, .out_active_o);

endmodule

`default_nettype wire

// File: verilog/video_mux.sv
`timescale 1ns/1ps
`default_nettype none

module video_mux #(
  parameter int H_ACTIVE = 1280,
  parameter int V_ACTIVE = 720
) (
  input  wire                       clk_pixel,
  input  wire                       recent_reset,
  input  wire tracker_pkg::view_t   view_i,
  input  wire tracker_pkg::rgb565_t pix_i,
  input  wire tracker_pkg::chan_t   chan_i,
  input  wire                       mask_i,
  input  wire tracker_pkg::hcoord_t hcount_i,
  input  wire tracker_pkg::vcoord_t vcount_i,
  input  wire                       active_i,
  input  wire tracker_pkg::hcoord_t x_com_i,
  input  wire tracker_pkg::vcoord_t y_com_i,
  output tracker_pkg::rgb888_t      rgb_o,
  output tracker_pkg::hcoord_t      out_hcount_o,
  output tracker_pkg::vcoord_t      out_vcount_o,
  output logic                      out_active_o
);
  import tracker_pkg::*;

  rgb888_t cam;     // camera colour, zero-filled low bits
  rgb888_t pix_sel;
  logic    on_line; // crosshair hit

  assign cam     = {pix_i[15:11], 3'b000, pix_i[10:5], 2'b00, pix_i[4:0], 3'b000};
  assign on_line = (hcount_i == x_com_i) || (vcount_i == y_com_i);

  always_comb begin
    case (view_i)
      VIEW_CHANNEL:   pix_sel = {chan_i, chan_i, chan_i}; // gray
      VIEW_MASK:      pix_sel = {24{mask_i}};
      VIEW_CROSSHAIR: pix_sel = on_line ? 24'hFF_FFFF : cam;
      default:        pix_sel = cam;
    endcase
  end

  // stage 2
  always_ff @(posedge clk_pixel) begin
    if (recent_reset) begin
      rgb_o        <= '0;
      out_active_o <= 1'b0;
    end else begin
      rgb_o        <= active_i ? pix_sel : '0; // blanking is black
      out_active_o <= active_i;
    end
  end

  always_ff @(posedge clk_pixel) begin
    out_hcount_o <= hcount_i;
    out_vcount_o <= vcount_i;
  end

endmodule

`default_nettype wire

// File: verilog/video_timing.sv
`timescale 1ns/1ps
`default_nettype none

module video_timing #(
  parameter int H_ACTIVE = 1280,
  parameter int H_TOTAL  = 1650,
  parameter int V_ACTIVE = 720,
  parameter int V_TOTAL  = 750
) (
  input  wire                  clk_pixel,
  input  wire                  recent_reset,
  output tracker_pkg::hcoord_t req_hcount_o, // coordinate asked of the source
  output tracker_pkg::vcoord_t req_vcount_o,
  output logic                 req_active_o, // inside the visible area
  output logic                 frame_end_o   // last visible pixel of the frame
);
  import tracker_pkg::*;

  localparam hcoord_t H_LAST     = hcoord_t'(H_TOTAL - 1);
  localparam vcoord_t V_LAST     = vcoord_t'(V_TOTAL - 1);
  localparam hcoord_t H_ACT_LAST = hcoord_t'(H_ACTIVE - 1);
  localparam vcoord_t V_ACT_LAST = vcoord_t'(V_ACTIVE - 1);

  // scan never stalls, one position per clock
  always_ff @(posedge clk_pixel) begin
    if (recent_reset) begin
      req_hcount_o <= '0;
      req_vcount_o <= '0;
    end else if (req_hcount_o == H_LAST) begin
      req_hcount_o <= '0; // wrap line
      req_vcount_o <= (req_vcount_o == V_LAST) ? '0 : req_vcount_o + 1'b1;
    end else begin
      req_hcount_o <= req_hcount_o + 1'b1;
    end
  end

  // flags decoded straight off the counters, same cycle as the request
  assign req_active_o = (req_hcount_o < H_ACTIVE) && (req_vcount_o < V_ACTIVE);
  assign frame_end_o  = (req_hcount_o == H_ACT_LAST) && (req_vcount_o == V_ACT_LAST);

endmodule

`default_nettype wire

// File: verilog/wb_config_regs.sv
`timescale 1ns/1ps
`default_nettype none

module wb_config_regs (
  input  wire                    clk_pixel,
  input  wire                    recent_reset,
  input  wire                    wb_cyc_i,
  input  wire                    wb_stb_i,
  input  wire                    wb_we_i,
  input  wire  [1:0]             wb_adr_i,
  input  wire  [31:0]            wb_dat_i,
  output logic [31:0]            wb_dat_o,
  output logic                   wb_ack_o,
  input  wire tracker_pkg::hcoord_t x_com_i, // held divider result
  input  wire tracker_pkg::vcoord_t y_com_i,
  output tracker_pkg::chan_sel_t chan_sel_o,
  output tracker_pkg::view_t     view_o,
  output tracker_pkg::chan_t     lower_o,
  output tracker_pkg::chan_t     upper_o
);
  import tracker_pkg::*;

  logic req; // live request from the master

  assign req = wb_cyc_i && wb_stb_i;

  always_ff @(posedge clk_pixel) begin
    if (recent_reset) begin
      wb_ack_o   <= 1'b0;
      chan_sel_o <= CH_RED;
      view_o     <= VIEW_CAMERA;
      lower_o    <= 8'd0;
      upper_o    <= 8'd255; // whole range passes until told otherwise
    end else begin
      wb_ack_o <= req && !wb_ack_o; // single cycle ack, one cycle after request
      // write commits in the ack cycle, master still holds dat and adr
      if (req && wb_ack_o && wb_we_i) begin
        case (wb_adr_i)
          REG_CTRL: begin
            chan_sel_o <= chan_sel_t'(wb_dat_i[1:0]);
            view_o     <= view_t'(wb_dat_i[3:2]);
          end
          REG_LOWER: lower_o <= wb_dat_i[7:0];
          REG_UPPER: upper_o <= wb_dat_i[7:0];
          default: ; // REG_COM is read only
        endcase
      end
    end
  end

  // read mux, sampled by the master while ack is high
  always_comb begin
    case (wb_adr_i)
      REG_CTRL:  wb_dat_o = {28'd0, view_o, chan_sel_o};
      REG_LOWER: wb_dat_o = {24'd0, lower_o};
      REG_UPPER: wb_dat_o = {24'd0, upper_o};
      default:   wb_dat_o = {6'd0, y_com_i, 5'd0, x_com_i};
    endcase
  end

endmodule

`default_nettype wire
